// File: build.f
rtl/mem_pkg.sv
rtl/mem_array.sv
rtl/mem_ctrl.sv
rtl/cache_mem_arbiter.sv
rtl/mem_subsystem_top.sv
dv/tb_clock_gen.sv
dv/mem_subsystem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator and run it.
# The exit status is the simulator's, so a $fatal fails the script.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module mem_subsystem_tb -f build.f -o sim \
    && ./obj_dir/sim \
    || { echo "simulation did not complete cleanly"; exit 1; }

// File: dv/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int ADDR_W        = mem_pkg::ADDR_WIDTH;
    localparam int LINE_W        = mem_pkg::LINE_WIDTH;
    localparam int LATENCY       = 3;
    localparam int DEPTH_LOG2    = 4;
    localparam int MODEL_DEPTH   = 1 << DEPTH_LOG2;
    localparam int WAIT_LIMIT    = 50;
    localparam int RANDOM_TXNS   = 400;

    logic               clk;
    logic               reset;
    logic [ADDR_W-1:0]  icache_address;
    logic [ADDR_W-1:0]  dcache_address;
    logic               icache_req;
    logic               dcache_req;
    logic               wr_en;
    logic [LINE_W-1:0]  data_in;
    logic [LINE_W-1:0]  icache_data_out;
    logic [LINE_W-1:0]  dcache_data_out;
    logic               icache_operation_complete;
    logic               dcache_operation_complete;

    // reference memory, indexed like the array.
    logic [LINE_W-1:0]  model_lines [MODEL_DEPTH];
    bit                 model_written [MODEL_DEPTH];

    logic [31:0]        rng_state = 32'he747_d823;
    int                 cycle = 0;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (4)
    ) i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mem_subsystem_top #(
        .MEM_LATENCY    (LATENCY),
        .MEM_DEPTH_LOG2 (DEPTH_LOG2)
    ) i_mem_subsystem_top (
        .clk                       (clk),
        .reset                     (reset),
        .icache_address            (icache_address),
        .dcache_address            (dcache_address),
        .icache_req                (icache_req),
        .dcache_req                (dcache_req),
        .wr_en                     (wr_en),
        .data_in                   (data_in),
        .icache_data_out           (icache_data_out),
        .dcache_data_out           (dcache_data_out),
        .icache_operation_complete (icache_operation_complete),
        .dcache_operation_complete (dcache_operation_complete)
    );

    // ****************************************
    // random numbers.
    // ****************************************
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int random_below(input int n);
        return int'((next_random() >> 16) % 32'(n));
    endfunction

    function automatic logic [ADDR_W-1:0] random_address();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        // low LCG bits repeat quickly, so mix upper state bits into the index bits.
        lo = lo ^ (hi >> 16);
        return {hi, lo};
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] line;
        for (int i = 0; i < LINE_W / 32; i++) begin
            line[i*32 +: 32] = next_random();
        end
        return line;
    endfunction

    // ****************************************
    // memory model.
    // ****************************************
    function automatic int model_index(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] line_addr;
        line_addr = addr >> mem_pkg::LINE_OFFSET_BITS;
        return int'(line_addr % ADDR_W'(MODEL_DEPTH));
    endfunction

    function automatic logic [LINE_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        int idx;
        idx = model_index(addr);
        // unwritten lines read as zero.
        return model_written[idx] ? model_lines[idx] : '0;
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                        input logic [LINE_W-1:0] line);
        int idx;
        idx = model_index(addr);
        model_lines[idx]   = line;
        model_written[idx] = 1'b1;
    endfunction

    // ****************************************
    // checking.
    // ****************************************
    task automatic check_value(input string what, input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        $display("Regression failed");
        $fatal(1, "timeout");
    endtask

    task automatic next_edge();
        @(posedge clk);
        cycle = cycle + 1;
    endtask

    // no completion may show up while nothing is outstanding.
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_edge();
            @(negedge clk);
            check_value("icache pulse while idle", LINE_W'(icache_operation_complete), '0);
            check_value("dcache pulse while idle", LINE_W'(dcache_operation_complete), '0);
        end
    endtask

    // grant_edge is the edge at which the idle arbiter samples the request.
    task automatic wait_completion(input bit is_icache, input int grant_edge,
                                   input logic [LINE_W-1:0] expected);
        int  waited;
        bit  seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            next_edge();
            // the arbiter is idle again once this edge raises the pulse.
            if (cycle == grant_edge + LATENCY + 1) begin
                if (is_icache) begin
                    icache_req <= 1'b0;
                end else begin
                    dcache_req <= 1'b0;
                    wr_en      <= 1'b0;
                end
            end
            @(negedge clk);
            if (is_icache) begin
                check_value("dcache pulse during icache", LINE_W'(dcache_operation_complete), '0);
                seen = icache_operation_complete;
            end else begin
                check_value("icache pulse during dcache", LINE_W'(icache_operation_complete), '0);
                seen = dcache_operation_complete;
            end
            waited++;
            if (!seen && waited >= WAIT_LIMIT) begin
                report_timeout(is_icache ? "icache completion" : "dcache completion");
            end
        end
        check_value("completion edge", LINE_W'(cycle), LINE_W'(grant_edge + LATENCY + 1));
        if (is_icache) begin
            check_value("icache line", icache_data_out, expected);
        end else begin
            check_value("dcache line", dcache_data_out, expected);
        end
    endtask

    // one round raises one or both requests on the same edge.
    task automatic run_round(input bit do_icache, input logic [ADDR_W-1:0] i_addr,
                             input bit do_dcache, input logic [ADDR_W-1:0] d_addr,
                             input bit d_write, input logic [LINE_W-1:0] d_data);
        logic [LINE_W-1:0] exp_i;
        logic [LINE_W-1:0] exp_d;
        int                grant_edge;
        exp_i = '0;
        exp_d = '0;
        // icache is served first, so its read sees memory before the dcache access.
        if (do_icache) begin
            exp_i = model_read(i_addr);
        end
        if (do_dcache) begin
            if (d_write) begin
                model_write(d_addr, d_data);
                exp_d = d_data;
            end else begin
                exp_d = model_read(d_addr);
            end
        end

        next_edge();
        if (do_icache) begin
            icache_req     <= 1'b1;
            icache_address <= i_addr;
        end
        if (do_dcache) begin
            dcache_req     <= 1'b1;
            dcache_address <= d_addr;
            wr_en          <= d_write;
            data_in        <= d_data;
        end
        grant_edge = cycle + 1;
        if (do_icache) begin
            wait_completion(1'b1, grant_edge, exp_i);
            // a waiting dcache is sampled on the next edge.
            grant_edge = cycle + 1;
        end
        if (do_dcache) begin
            wait_completion(1'b0, grant_edge, exp_d);
        end
    endtask

    // ****************************************
    // test sequence.
    // ****************************************
    initial begin
        int                waited;
        int                done_count;
        int                kind;
        logic [ADDR_W-1:0] addr_a;
        logic [ADDR_W-1:0] addr_b;
        logic [LINE_W-1:0] line_a;
        logic [LINE_W-1:0] line_b;

        icache_req     <= 1'b0;
        dcache_req     <= 1'b0;
        wr_en          <= 1'b0;
        icache_address <= '0;
        dcache_address <= '0;
        data_in        <= '0;
        for (int i = 0; i < MODEL_DEPTH; i++) begin
            model_written[i] = 1'b0;
            model_lines[i]   = '0;
        end

        waited = 0;
        @(negedge clk);
        while (reset !== 1'b0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("reset release");
            end
            @(negedge clk);
        end

        idle_cycles(8);

        // cold read, write, read back, then an aliased write to the same index.
        addr_a = 64'h0000_0000_0000_1040;
        addr_b = addr_a + (64'(MODEL_DEPTH) << mem_pkg::LINE_OFFSET_BITS);
        line_a = random_line();
        line_b = random_line();
        run_round(1'b1, addr_a, 1'b0, '0, 1'b0, '0);
        check_value("unwritten line", icache_data_out, '0);
        run_round(1'b0, '0, 1'b1, addr_a, 1'b1, line_a);
        check_value("write echo", dcache_data_out, data_in);
        run_round(1'b0, '0, 1'b1, addr_a, 1'b0, random_line());
        run_round(1'b1, addr_a, 1'b0, '0, 1'b0, '0);
        run_round(1'b0, '0, 1'b1, addr_b, 1'b1, line_b);
        run_round(1'b1, addr_a, 1'b0, '0, 1'b0, '0);
        check_value("aliased write", icache_data_out, line_b);
        idle_cycles(3);

        // both requests on one edge.
        run_round(1'b1, addr_b, 1'b1, random_address(), 1'b1, random_line());
        run_round(1'b1, random_address(), 1'b1, addr_a, 1'b0, random_line());

        done_count = 0;
        while (done_count < RANDOM_TXNS) begin
            kind = random_below(3);
            if (kind == 2 && done_count == RANDOM_TXNS - 1) begin
                kind = 0;
            end
            idle_cycles(random_below(4));
            run_round(kind != 1, random_address(), kind != 0, random_address(),
                      random_below(2) == 1, random_line());
            done_count += (kind == 2) ? 2 : 1;
        end

        idle_cycles(4);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is released on a rising edge, like any other stimulus.
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int MEM_LATENCY    = 3,
    parameter int MEM_DEPTH_LOG2 = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  icache_address,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  dcache_address,
    input  logic                            icache_req,
    input  logic                            dcache_req,
    input  logic                            wr_en,
    input  logic [mem_pkg::LINE_WIDTH-1:0]  data_in,
    output logic [mem_pkg::LINE_WIDTH-1:0]  icache_data_out,
    output logic [mem_pkg::LINE_WIDTH-1:0]  dcache_data_out,
    output logic                            icache_operation_complete,
    output logic                            dcache_operation_complete
);

    // arbiter to controller.
    logic [mem_pkg::ADDR_WIDTH-1:0]  mem_address;
    logic [mem_pkg::LINE_WIDTH-1:0]  mem_data_out;
    logic                            mem_req;
    logic                            mem_wr_en;
    logic [mem_pkg::LINE_WIDTH-1:0]  data_from_mem;
    logic                            mem_data_valid;

    // controller to array.
    logic                            array_en;
    logic                            array_we;
    logic [MEM_DEPTH_LOG2-1:0]       array_index;
    logic [mem_pkg::LINE_WIDTH-1:0]  array_wdata;
    logic [mem_pkg::LINE_WIDTH-1:0]  array_rdata;

    // ****************************************
    // grant stage.
    // ****************************************
    cache_mem_arbiter i_cache_mem_arbiter (
        .clk                       (clk),
        .reset                     (reset),
        .icache_address            (icache_address),
        .dcache_address            (dcache_address),
        .icache_req                (icache_req),
        .dcache_req                (dcache_req),
        .wr_en                     (wr_en),
        .data_in                   (data_in),
        .icache_data_out           (icache_data_out),
        .dcache_data_out           (dcache_data_out),
        .icache_operation_complete (icache_operation_complete),
        .dcache_operation_complete (dcache_operation_complete),
        .data_from_mem             (data_from_mem),
        .mem_data_valid            (mem_data_valid),
        .mem_address               (mem_address),
        .mem_data_out              (mem_data_out),
        .mem_req                   (mem_req),
        .mem_wr_en                 (mem_wr_en)
    );

    // ****************************************
    // command stage.
    // ****************************************
    mem_ctrl #(
        .MEM_LATENCY    (MEM_LATENCY),
        .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) i_mem_ctrl (
        .clk            (clk),
        .reset          (reset),
        .mem_req        (mem_req),
        .mem_address    (mem_address),
        .mem_data_out   (mem_data_out),
        .mem_wr_en      (mem_wr_en),
        .data_from_mem  (data_from_mem),
        .mem_data_valid (mem_data_valid),
        .array_en       (array_en),
        .array_we       (array_we),
        .array_index    (array_index),
        .array_wdata    (array_wdata),
        .array_rdata    (array_rdata)
    );

    // ****************************************
    // array stage.
    // ****************************************
    mem_array #(
        .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) i_mem_array (
        .clk         (clk),
        .reset       (reset),
        .array_en    (array_en),
        .array_we    (array_we),
        .array_index (array_index),
        .array_wdata (array_wdata),
        .array_rdata (array_rdata)
    );

endmodule

// File: rtl/cache_mem_arbiter.sv
`timescale 1ns/1ps

module cache_mem_arbiter (
    input  logic                            clk,
    input  logic                            reset,

    // cache requests.
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  icache_address,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  dcache_address,
    input  logic                            icache_req,
    input  logic                            dcache_req,
    input  logic                            wr_en,
    input  logic [mem_pkg::LINE_WIDTH-1:0]  data_in,

    // completion back to the caches.
    output logic [mem_pkg::LINE_WIDTH-1:0]  icache_data_out,
    output logic [mem_pkg::LINE_WIDTH-1:0]  dcache_data_out,
    output logic                            icache_operation_complete,
    output logic                            dcache_operation_complete,

    // response from the memory controller.
    input  logic [mem_pkg::LINE_WIDTH-1:0]  data_from_mem,
    input  logic                            mem_data_valid,

    // command to the memory controller.
    output logic [mem_pkg::ADDR_WIDTH-1:0]  mem_address,
    output logic [mem_pkg::LINE_WIDTH-1:0]  mem_data_out,
    output logic                            mem_req,
    output logic                            mem_wr_en
);

    mem_pkg::arb_state_t state;
    mem_pkg::arb_state_t next_state;

    logic grant_icache;
    logic grant_dcache;
    logic icache_done;
    logic dcache_done;

    // ****************************************
    // grant and next state.
    // ****************************************

    // icache has fixed priority over dcache.
    assign grant_icache = (state == mem_pkg::ARB_IDLE) && icache_req;
    assign grant_dcache = (state == mem_pkg::ARB_IDLE) && !icache_req && dcache_req;

    // busy holds until the response is routed back.
    assign icache_done = (state == mem_pkg::ARB_ICACHE) && mem_data_valid;
    assign dcache_done = (state == mem_pkg::ARB_DCACHE) && mem_data_valid;

    always_comb begin
        next_state = state;
        if (grant_icache) begin
            next_state = mem_pkg::ARB_ICACHE;
        end else if (grant_dcache) begin
            next_state = mem_pkg::ARB_DCACHE;
        end else if (icache_done || dcache_done) begin
            next_state = mem_pkg::ARB_IDLE;
        end
    end

    // ****************************************
    // control registers.
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state                     <= mem_pkg::ARB_IDLE;
            mem_req                   <= 1'b0;
            mem_wr_en                 <= 1'b0;
            icache_operation_complete <= 1'b0;
            dcache_operation_complete <= 1'b0;
        end else begin
            state                     <= next_state;
            mem_req                   <= grant_icache || grant_dcache;
            mem_wr_en                 <= grant_dcache && wr_en;
            icache_operation_complete <= icache_done;
            dcache_operation_complete <= dcache_done;
        end
    end

    // ****************************************
    // payload registers.
    // ****************************************
    always_ff @(posedge clk) begin
        if (grant_icache) begin
            mem_address  <= icache_address;
            mem_data_out <= '0;
        end else if (grant_dcache) begin
            mem_address  <= dcache_address;
            // reads carry no data toward memory.
            mem_data_out <= wr_en ? data_in : '0;
        end

        if (icache_done) begin
            icache_data_out <= data_from_mem;
        end
        if (dcache_done) begin
            dcache_data_out <= data_from_mem;
        end
    end

endmodule

// File: rtl/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl #(
    parameter int MEM_LATENCY    = 3,
    parameter int MEM_DEPTH_LOG2 = 4
) (
    input  logic                            clk,
    input  logic                            reset,

    // command from the arbiter.
    input  logic                            mem_req,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  mem_address,
    input  logic [mem_pkg::LINE_WIDTH-1:0]  mem_data_out,
    input  logic                            mem_wr_en,

    // response to the arbiter.
    output logic [mem_pkg::LINE_WIDTH-1:0]  data_from_mem,
    output logic                            mem_data_valid,

    // array access.
    output logic                            array_en,
    output logic                            array_we,
    output logic [MEM_DEPTH_LOG2-1:0]       array_index,
    output logic [mem_pkg::LINE_WIDTH-1:0]  array_wdata,
    input  logic [mem_pkg::LINE_WIDTH-1:0]  array_rdata
);

    // stage 0 is loaded on the edge that accepts a command.
    logic [MEM_LATENCY-1:0]          pipe_valid;
    logic [mem_pkg::LINE_WIDTH-1:0]  pipe_data [MEM_LATENCY];

    // the op only steers what stage 1 captures.
    mem_pkg::mem_op_t                stage0_op;

    // ****************************************
    // array access.
    // ****************************************

    // the array samples on the same edge that accepts the command.
    assign array_en    = mem_req;
    assign array_we    = mem_req && mem_wr_en;
    assign array_index = mem_address[mem_pkg::LINE_OFFSET_BITS +: MEM_DEPTH_LOG2];
    assign array_wdata = mem_data_out;

    // ****************************************
    // latency pipeline.
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], mem_req};
        end
    end

    always_ff @(posedge clk) begin
        stage0_op    <= mem_wr_en ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
        pipe_data[0] <= mem_data_out;

        // read data is on array_rdata while the record sits in stage 0.
        if (stage0_op == mem_pkg::MEM_READ) begin
            pipe_data[1] <= array_rdata;
        end else begin
            pipe_data[1] <= pipe_data[0];
        end

        for (int i = 2; i < MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    // ****************************************
    // response.
    // ****************************************

    // the last stage holds the array line for a read and the written line for a write.
    assign mem_data_valid = pipe_valid[MEM_LATENCY-1];
    assign data_from_mem  = pipe_data[MEM_LATENCY-1];

endmodule

// File: rtl/mem_array.sv
`timescale 1ns/1ps

module mem_array #(
    parameter int MEM_DEPTH_LOG2 = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            array_en,
    input  logic                            array_we,
    input  logic [MEM_DEPTH_LOG2-1:0]       array_index,
    input  logic [mem_pkg::LINE_WIDTH-1:0]  array_wdata,
    output logic [mem_pkg::LINE_WIDTH-1:0]  array_rdata
);

    localparam int DEPTH = 1 << MEM_DEPTH_LOG2;

    logic [mem_pkg::LINE_WIDTH-1:0]  lines [DEPTH];
    logic [DEPTH-1:0]                written;

    // ****************************************
    // line storage.
    // ****************************************
    always_ff @(posedge clk) begin
        if (array_en && array_we) begin
            lines[array_index] <= array_wdata;
        end
    end

    // one flag per line, set on the first write.
    always_ff @(posedge clk) begin
        if (reset) begin
            written <= '0;
        end else if (array_en && array_we) begin
            written[array_index] <= 1'b1;
        end
    end

    // ****************************************
    // read port.
    // ****************************************

    // lines never written read back as zero.
    always_ff @(posedge clk) begin
        if (array_en) begin
            if (written[array_index]) begin
                array_rdata <= lines[array_index];
            end else begin
                array_rdata <= '0;
            end
        end
    end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

    // ****************************************
    // address and line geometry.
    // ****************************************
    parameter int ADDR_WIDTH = 64;
    parameter int LINE_WIDTH = 512;

    // 64-byte line.
    parameter int LINE_OFFSET_BITS = 6;

    // ****************************************
    // shared encodings.
    // ****************************************

    // arbiter grant state.
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_ICACHE = 2'd1,
        ARB_DCACHE = 2'd2
    } arb_state_t;

    // memory command kind.
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage
